/* src/sat_fixed_pkg.sv */
package sat_fixed_pkg;

    // Input position format: pixels with POS_FRAC fraction bits
    localparam int POS_W    = 32;
    localparam int POS_FRAC = 11;

    // Rectangle width and height in whole pixels, unsigned
    localparam int DIM_W = 8;

    // Unit axis component width
    localparam int AXIS_W = 16;

    // Internal coordinate width
    // Pixels scaled by the axis fraction bits, with headroom for corner sums
    localparam int COORD_W = 40;

    // Signed internal coordinate, shared by every stage
    typedef logic signed [COORD_W-1:0] coord_t;

    // Signed axis component
    typedef logic signed [AXIS_W-1:0] axis_t;

    // Half of a width or height, low bit dropped
    typedef logic [DIM_W-2:0] half_t;

endpackage

/* src/sat_geom_pkg.sv */
package sat_geom_pkg;

    // Point in internal coordinates
    typedef struct packed {
        sat_fixed_pkg::coord_t x;
        sat_fixed_pkg::coord_t y;
    } point_t;

    // Corner order (-hw,-hh), (-hw,+hh), (+hw,-hh), (+hw,+hh)
    // Bit 1 of the index picks the width sign, bit 0 the height sign
    typedef point_t [3:0] corners_t;

    // Unit axes u and v of one rectangle
    typedef struct packed {
        sat_fixed_pkg::axis_t u_x;
        sat_fixed_pkg::axis_t u_y;
        sat_fixed_pkg::axis_t v_x;
        sat_fixed_pkg::axis_t v_y;
    } axes_t;

    // Extent of four projections on one axis
    typedef struct packed {
        sat_fixed_pkg::coord_t lo;
        sat_fixed_pkg::coord_t hi;
    } extent_t;

    // Projections of four corners, index [corner][0 = u, 1 = v]
    typedef sat_fixed_pkg::coord_t [3:0][1:0] proj_t;

    // One rectangle as it travels down the pipeline
    typedef struct packed {
        point_t                centre;
        axes_t                 axes;
        sat_fixed_pkg::half_t  half_w;
        sat_fixed_pkg::half_t  half_h;
    } rect_frame_t;

endpackage

/* src/corner_if.sv */
`timescale 1ns/1ps

// Stage 1 to stage 2 link
// Carries both rectangle frames and their corners
interface corner_if;

    // Qualifies the frames and corners below
    logic                     valid;

    // Centre, axes and half extents of each rectangle
    sat_geom_pkg::rect_frame_t frame_a;
    sat_geom_pkg::rect_frame_t frame_b;

    // Corners in internal coordinates
    sat_geom_pkg::corners_t    corners_a;
    sat_geom_pkg::corners_t    corners_b;

    // Corner generator side
    modport src (
        output valid,
        output frame_a,
        output frame_b,
        output corners_a,
        output corners_b
    );

    // Projection stage side
    modport dst (
        input valid,
        input frame_a,
        input frame_b,
        input corners_a,
        input corners_b
    );

endinterface

/* src/proj_if.sv */
`timescale 1ns/1ps

// Stage 2 to stage 3 link
interface proj_if;

    logic                  valid;

    // Corners of A relative to B's centre, on B's axes, and the reverse
    sat_geom_pkg::proj_t   proj_a_on_b;
    sat_geom_pkg::proj_t   proj_b_on_a;

    // Half extents, index 0 is half width and 1 is half height
    sat_fixed_pkg::half_t [1:0] half_a;
    sat_fixed_pkg::half_t [1:0] half_b;

    modport src (
        output valid,
        output proj_a_on_b,
        output proj_b_on_a,
        output half_a,
        output half_b
    );

    modport dst (
        input valid,
        input proj_a_on_b,
        input proj_b_on_a,
        input half_a,
        input half_b
    );

endinterface

/* src/corner_gen.sv */
`timescale 1ns/1ps

// Stage 1: build frames and corners of both rectangles
module corner_gen #(
    parameter int AXIS_FRAC = 14
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic signed [sat_fixed_pkg::POS_W-1:0] pos_a_x,
    input  logic signed [sat_fixed_pkg::POS_W-1:0] pos_a_y,
    input  logic [sat_fixed_pkg::DIM_W-1:0]        width_a,
    input  logic [sat_fixed_pkg::DIM_W-1:0]        height_a,
    input  sat_geom_pkg::axes_t                    axes_a,
    input  logic signed [sat_fixed_pkg::POS_W-1:0] pos_b_x,
    input  logic signed [sat_fixed_pkg::POS_W-1:0] pos_b_y,
    input  logic [sat_fixed_pkg::DIM_W-1:0]        width_b,
    input  logic [sat_fixed_pkg::DIM_W-1:0]        height_b,
    input  sat_geom_pkg::axes_t                    axes_b,
    corner_if.src                                 cout
);

    sat_geom_pkg::rect_frame_t frame_a;
    sat_geom_pkg::rect_frame_t frame_b;

    // Drop the position fraction, then move to the axis scale
    function automatic sat_geom_pkg::rect_frame_t make_frame(
        input logic signed [sat_fixed_pkg::POS_W-1:0] px,
        input logic signed [sat_fixed_pkg::POS_W-1:0] py,
        input logic [sat_fixed_pkg::DIM_W-1:0]        w,
        input logic [sat_fixed_pkg::DIM_W-1:0]        h,
        input sat_geom_pkg::axes_t                    ax
    );
        sat_geom_pkg::rect_frame_t f;
        f.centre.x = sat_fixed_pkg::coord_t'(px >>> sat_fixed_pkg::POS_FRAC) <<< AXIS_FRAC;
        f.centre.y = sat_fixed_pkg::coord_t'(py >>> sat_fixed_pkg::POS_FRAC) <<< AXIS_FRAC;
        f.axes     = ax;
        f.half_w   = w[sat_fixed_pkg::DIM_W-1:1];
        f.half_h   = h[sat_fixed_pkg::DIM_W-1:1];
        return f;
    endfunction

    // Corner = centre +/- half width * u +/- half height * v
    function automatic sat_geom_pkg::corners_t make_corners(
        input sat_geom_pkg::rect_frame_t f
    );
        sat_fixed_pkg::coord_t  wu_x;
        sat_fixed_pkg::coord_t  wu_y;
        sat_fixed_pkg::coord_t  hv_x;
        sat_fixed_pkg::coord_t  hv_y;
        sat_geom_pkg::corners_t k;
        wu_x = $signed({1'b0, f.half_w}) * f.axes.u_x;
        wu_y = $signed({1'b0, f.half_w}) * f.axes.u_y;
        hv_x = $signed({1'b0, f.half_h}) * f.axes.v_x;
        hv_y = $signed({1'b0, f.half_h}) * f.axes.v_y;
        for (int i = 0; i < 4; i++) begin
            k[i].x = f.centre.x + (i[1] ? wu_x : -wu_x) + (i[0] ? hv_x : -hv_x);
            k[i].y = f.centre.y + (i[1] ? wu_y : -wu_y) + (i[0] ? hv_y : -hv_y);
        end
        return k;
    endfunction

    assign frame_a = make_frame(pos_a_x, pos_a_y, width_a, height_a, axes_a);
    assign frame_b = make_frame(pos_b_x, pos_b_y, width_b, height_b, axes_b);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cout.valid <= 1'b0;
        end else begin
            cout.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            cout.frame_a   <= frame_a;
            cout.frame_b   <= frame_b;
            cout.corners_a <= make_corners(frame_a);
            cout.corners_b <= make_corners(frame_b);
        end
    end

endmodule

/* src/axis_project.sv */
`timescale 1ns/1ps

// Stage 2: project each rectangle's corners onto the other's axes
module axis_project #(
    parameter int AXIS_FRAC = 14
) (
    input  logic  clk,
    input  logic  rst_n,
    corner_if.dst cin,
    proj_if.src   pout
);

    // Full product width before the axis fraction is removed
    localparam int PROD_W = sat_fixed_pkg::COORD_W + sat_fixed_pkg::AXIS_W;

    // Dot product of a relative point with one unit axis
    function automatic sat_fixed_pkg::coord_t dot(
        input sat_fixed_pkg::coord_t dx,
        input sat_fixed_pkg::coord_t dy,
        input sat_fixed_pkg::axis_t  ax,
        input sat_fixed_pkg::axis_t  ay
    );
        logic signed [PROD_W-1:0] acc;
        acc = dx * ax + dy * ay;
        // Back to pixels with AXIS_FRAC fraction bits
        return sat_fixed_pkg::coord_t'(acc >>> AXIS_FRAC);
    endfunction

    // Four corners relative to the other centre, on the other's u and v
    function automatic sat_geom_pkg::proj_t project(
        input sat_geom_pkg::corners_t    pts,
        input sat_geom_pkg::rect_frame_t other
    );
        sat_geom_pkg::proj_t   res;
        sat_fixed_pkg::coord_t dx;
        sat_fixed_pkg::coord_t dy;
        for (int i = 0; i < 4; i++) begin
            dx = pts[i].x - other.centre.x;
            dy = pts[i].y - other.centre.y;
            res[i][0] = dot(dx, dy, other.axes.u_x, other.axes.u_y);
            res[i][1] = dot(dx, dy, other.axes.v_x, other.axes.v_y);
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pout.valid <= 1'b0;
        end else begin
            pout.valid <= cin.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cin.valid) begin
            pout.proj_a_on_b <= project(cin.corners_a, cin.frame_b);
            pout.proj_b_on_a <= project(cin.corners_b, cin.frame_a);
            // Half extents ride along for the stage 3 compares
            pout.half_a      <= {cin.frame_a.half_h, cin.frame_a.half_w};
            pout.half_b      <= {cin.frame_b.half_h, cin.frame_b.half_w};
        end
    end

endmodule

/* src/separation_test.sv */
`timescale 1ns/1ps

// Stage 3: min/max reduction and the eight separating-axis checks
module separation_test #(
    parameter int AXIS_FRAC = 14
) (
    input  logic clk,
    input  logic rst_n,
    proj_if.dst  pin,
    output logic out_valid,
    output logic is_collision
);

    // Extents on the other rectangle's u (0) and v (1)
    sat_geom_pkg::extent_t ext_ab [2];
    sat_geom_pkg::extent_t ext_ba [2];
    logic                  separated;

    // True min and max over all four corners on one axis
    function automatic sat_geom_pkg::extent_t reduce(
        input sat_geom_pkg::proj_t p,
        input int                  axis
    );
        sat_geom_pkg::extent_t e;
        sat_fixed_pkg::coord_t val;
        e.lo = p[0][axis];
        e.hi = p[0][axis];
        for (int i = 1; i < 4; i++) begin
            val = p[i][axis];
            if (val < e.lo) begin
                e.lo = val;
            end
            if (val > e.hi) begin
                e.hi = val;
            end
        end
        return e;
    endfunction

    // Touching edges count as separated
    function automatic logic outside(
        input sat_geom_pkg::extent_t e,
        input sat_fixed_pkg::half_t  h
    );
        sat_fixed_pkg::coord_t lim;
        lim = sat_fixed_pkg::coord_t'(h) <<< AXIS_FRAC;
        return (e.lo >= lim) || (e.hi <= -lim);
    endfunction

    always_comb begin
        separated = 1'b0;
        for (int s = 0; s < 2; s++) begin
            ext_ab[s] = reduce(pin.proj_a_on_b, s);
            ext_ba[s] = reduce(pin.proj_b_on_a, s);
            separated = separated | outside(ext_ab[s], pin.half_b[s]);
            separated = separated | outside(ext_ba[s], pin.half_a[s]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            is_collision <= 1'b0;
        end else begin
            out_valid <= pin.valid;
            if (pin.valid) begin
                is_collision <= ~separated;
            end
        end
    end

endmodule

/* src/collision_detector.sv */
`timescale 1ns/1ps

// Three-stage separating axis collision detector for two rotated rectangles
module collision_detector #(
    parameter int AXIS_FRAC = 14
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic [sat_fixed_pkg::DIM_W-1:0]        width_a,
    input  logic [sat_fixed_pkg::DIM_W-1:0]        height_a,
    input  logic [sat_fixed_pkg::DIM_W-1:0]        width_b,
    input  logic [sat_fixed_pkg::DIM_W-1:0]        height_b,
    input  logic signed [sat_fixed_pkg::POS_W-1:0] pos_a_x,
    input  logic signed [sat_fixed_pkg::POS_W-1:0] pos_a_y,
    input  logic signed [sat_fixed_pkg::POS_W-1:0] pos_b_x,
    input  logic signed [sat_fixed_pkg::POS_W-1:0] pos_b_y,
    input  sat_fixed_pkg::axis_t                   u_a_x,
    input  sat_fixed_pkg::axis_t                   u_a_y,
    input  sat_fixed_pkg::axis_t                   v_a_x,
    input  sat_fixed_pkg::axis_t                   v_a_y,
    input  sat_fixed_pkg::axis_t                   u_b_x,
    input  sat_fixed_pkg::axis_t                   u_b_y,
    input  sat_fixed_pkg::axis_t                   v_b_x,
    input  sat_fixed_pkg::axis_t                   v_b_y,
    output logic                                  out_valid,
    output logic                                  is_collision
);

    sat_geom_pkg::axes_t axes_a;
    sat_geom_pkg::axes_t axes_b;

    corner_if i_corner_if ();
    proj_if   i_proj_if ();

    assign axes_a = '{u_x: u_a_x, u_y: u_a_y, v_x: v_a_x, v_y: v_a_y};
    assign axes_b = '{u_x: u_b_x, u_y: u_b_y, v_x: v_b_x, v_y: v_b_y};

    corner_gen #(
        .AXIS_FRAC (AXIS_FRAC)
    ) i_corner_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .pos_a_x  (pos_a_x),
        .pos_a_y  (pos_a_y),
        .width_a  (width_a),
        .height_a (height_a),
        .axes_a   (axes_a),
        .pos_b_x  (pos_b_x),
        .pos_b_y  (pos_b_y),
        .width_b  (width_b),
        .height_b (height_b),
        .axes_b   (axes_b),
        .cout     (i_corner_if.src)
    );

    axis_project #(
        .AXIS_FRAC (AXIS_FRAC)
    ) i_axis_project (
        .clk   (clk),
        .rst_n (rst_n),
        .cin   (i_corner_if.dst),
        .pout  (i_proj_if.src)
    );

    separation_test #(
        .AXIS_FRAC (AXIS_FRAC)
    ) i_separation_test (
        .clk          (clk),
        .rst_n        (rst_n),
        .pin          (i_proj_if.dst),
        .out_valid    (out_valid),
        .is_collision (is_collision)
    );

endmodule

/* sim/tb_cases.svh */
    // Directed rectangle pairs
    task automatic load_case_table();
        // Each row holds A x, y, width, height and turn, then the same for B, then the flag
        // Positions in whole pixels
        // Turn 0 is aligned, 1 a quarter turn, 2 is 45 degrees and 3 is 30 degrees

        // Aligned overlap and clear separation on each side
        add_case(   0,    0, 20, 10, 0,    5,    3,  10,  10, 0, 1'b1);
        add_case(   0,    0, 20, 10, 0,   20,    0,  10,  10, 0, 1'b0);
        add_case(   0,    0, 20, 10, 0,  -16,    2,  10,  10, 0, 1'b0);
        add_case(   0,    0, 20, 10, 0,    0,   11,  10,  10, 0, 1'b0);
        add_case(   0,    0, 20, 10, 0,    3,  -12,  10,  10, 0, 1'b0);
        // Exact edge and corner contact, then a near miss that overlaps
        add_case(   0,    0, 20, 10, 0,   15,    0,  10,  10, 0, 1'b0);
        add_case(   0,    0, 20, 10, 0,    0,  -10,  10,  10, 0, 1'b0);
        add_case(   0,    0, 20, 10, 0,   15,   10,  10,  10, 0, 1'b0);
        add_case(   0,    0, 20, 10, 0,   14,    9,  10,  10, 0, 1'b1);
        add_case( -30,   40,  8,  8, 0,  -30,   40,   8,   8, 0, 1'b1);
        add_case(-100, -200, 40, 20, 0,  -80, -195,   6,   4, 0, 1'b1);
        // Quarter turns swap width and height
        add_case(   0,    0, 20, 10, 1,   12,    0,  10,  10, 0, 1'b0);
        add_case(   0,    0, 20, 10, 1,    0,   14,  10,  10, 0, 1'b1);
        add_case(   0,    0, 20, 10, 1,   10,    0,  10,  10, 0, 1'b0);
        add_case(  50,   50, 30,  6, 1,   50,   70,   4,  12, 1, 1'b0);
        add_case(  50,   50, 30,  6, 1,   55,   64,   4,  12, 1, 1'b1);
        add_case(   0,    0,  6, 40, 0,   10,    0,  30,   4, 1, 1'b0);
        // Small rectangle inside a large rotated one
        add_case(   2,    3,  4,  4, 0,    0,    0, 100, 100, 2, 1'b1);
        add_case( 100,  -50, 60, 40, 3,  103,  -48,   6,   4, 2, 1'b1);
        add_case( -20,   10,  8,  4, 2,  -20,   10,  40,  20, 2, 1'b1);
        add_case(   0,    0, 10,  6, 3,    1,   -1,  64,  64, 1, 1'b1);
        // Rotated squares far apart
        add_case(   0,    0, 10, 10, 2,   40,    0,  10,  10, 2, 1'b0);
    endtask

/* sim/tb_collision_detector.sv */
`timescale 1ns/1ps

module tb_collision_detector;

    localparam logic [31:0] LFSR_SEED     = 32'h8546c564;
    localparam int          RANDOM_CASES  = 100;
    localparam int          DRAIN_TIMEOUT = 20;
    localparam int          PF            = sat_fixed_pkg::POS_FRAC;

    // One rectangle pair in input format with its expected flag
    typedef struct packed {
        logic signed [sat_fixed_pkg::POS_W-1:0] ax, ay, bx, by;
        logic [sat_fixed_pkg::DIM_W-1:0]        wa, ha, wb, hb;
        logic [1:0]                             ra, rb;
        logic                                   hit;
    } rect_pair_t;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   in_valid;
    logic [sat_fixed_pkg::DIM_W-1:0]        width_a, height_a, width_b, height_b;
    logic signed [sat_fixed_pkg::POS_W-1:0] pos_a_x, pos_a_y, pos_b_x, pos_b_y;
    sat_fixed_pkg::axis_t                   u_a_x, u_a_y, v_a_x, v_a_y;
    sat_fixed_pkg::axis_t                   u_b_x, u_b_y, v_b_x, v_b_y;
    logic                                   out_valid;
    logic                                   is_collision;

    rect_pair_t  case_table [$];
    logic        exp_flags [$];
    int          exp_ids [$];
    logic [31:0] lfsr_state;
    int          mismatch_count = 0;
    int          other_count    = 0;
    int          results_seen   = 0;

    collision_detector #(.AXIS_FRAC(14)) i_collision_detector (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
    endtask

    // Axes with 14 fraction bits packed as u_x, u_y, v_x, v_y
    function automatic sat_geom_pkg::axes_t axes_for(input logic [1:0] rot);
        case (rot)
            2'd0: return {16'sd16384, 16'sd0, 16'sd0, 16'sd16384};
            2'd1: return {16'sd0, 16'sd16384, -16'sd16384, 16'sd0};
            2'd2: return {16'sd11585, 16'sd11585, -16'sd11585, 16'sd11585};
            default: return {16'sd14189, 16'sd8192, -16'sd8192, 16'sd14189};
        endcase
    endfunction

    // Aligned rule where touching edges do not collide
    function automatic logic aligned_overlap(input int ax, ay, wa, ha, bx, by, wb, hb);
        int dx;
        int dy;
        dx = (ax > bx) ? ax - bx : bx - ax;
        dy = (ay > by) ? ay - by : by - ay;
        return (dx < wa / 2 + wb / 2) && (dy < ha / 2 + hb / 2);
    endfunction

    task automatic add_case(input int ax, ay, wa, ha, ra, bx, by, wb, hb, rb, input logic hit);
        case_table.push_back('{ax <<< PF, ay <<< PF, bx <<< PF, by <<< PF, 8'(wa), 8'(ha),
                               8'(wb), 8'(hb), 2'(ra), 2'(rb), hit});
    endtask

    `include "tb_cases.svh"

    // Pixel in -64..63 plus a random fraction below one pixel
    task automatic random_position(output int pix, output logic signed [31:0] raw);
        logic [31:0] r;
        take_bits(7, r);
        pix = $signed(r[6:0]);
        take_bits(PF, r);
        raw = (pix <<< PF) | r[PF-1:0];
    endtask

    task automatic random_aligned_pair(output rect_pair_t p);
        logic [31:0] r;
        int          pix [4];
        int          dim [4];
        random_position(pix[0], p.ax);
        random_position(pix[1], p.ay);
        random_position(pix[2], p.bx);
        random_position(pix[3], p.by);
        // Even sizes from 2 to 64
        for (int i = 0; i < 4; i++) begin
            take_bits(5, r);
            dim[i] = 2 * r[4:0] + 2;
        end
        {p.wa, p.ha, p.wb, p.hb} = {8'(dim[0]), 8'(dim[1]), 8'(dim[2]), 8'(dim[3])};
        {p.ra, p.rb} = 4'b0;
        p.hit = aligned_overlap(pix[0], pix[1], dim[0], dim[1], pix[2], pix[3], dim[2], dim[3]);
    endtask

    task automatic drive_pair(input rect_pair_t p, input int id);
        sat_geom_pkg::axes_t axa;
        sat_geom_pkg::axes_t axb;
        axa = axes_for(p.ra);
        axb = axes_for(p.rb);
        @(posedge clk);
        in_valid <= 1'b1;
        {pos_a_x, pos_a_y, width_a, height_a} <= {p.ax, p.ay, p.wa, p.ha};
        {pos_b_x, pos_b_y, width_b, height_b} <= {p.bx, p.by, p.wb, p.hb};
        {u_a_x, u_a_y, v_a_x, v_a_y} <= axa;
        {u_b_x, u_b_y, v_b_x, v_b_y} <= axb;
        exp_flags.push_back(p.hit);
        exp_ids.push_back(id);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // Output monitor on the falling edge
    // out_valid trails in_valid by three falling edges
    initial begin
        logic [2:0] valid_hist;
        logic       want;
        int         id;
        valid_hist = '0;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (out_valid !== valid_hist[2]) begin
                $display("MISMATCH at %0t: out_valid %b, expected %b",
                         $time, out_valid, valid_hist[2]);
                mismatch_count++;
            end
            if (out_valid === 1'b1) begin
                if (exp_flags.size() == 0) begin
                    $display("ERROR at %0t: a result came out with no case pending", $time);
                    other_count++;
                end else begin
                    want = exp_flags.pop_front();
                    id   = exp_ids.pop_front();
                    results_seen++;
                    if (is_collision !== want) begin
                        $display("MISMATCH at %0t: case %0d is_collision %b, expected %b",
                                 $time, id, is_collision, want);
                        mismatch_count++;
                    end
                end
            end else if (results_seen == 0 && is_collision !== 1'b0) begin
                $display("MISMATCH at %0t: is_collision %b before any result, expected 0",
                         $time, is_collision);
                mismatch_count++;
            end
            valid_hist = {valid_hist[1:0], in_valid};
        end
    end

    initial begin
        rect_pair_t p;
        int         n_directed;
        int         waited;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        {width_a, height_a, width_b, height_b} = '0;
        {pos_a_x, pos_a_y, pos_b_x, pos_b_y}   = '0;
        {u_a_x, u_a_y, v_a_x, v_a_y, u_b_x, u_b_y, v_b_x, v_b_y} = '0;
        lfsr_state = LFSR_SEED;
        load_case_table();
        n_directed = case_table.size();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // Idle after reset while the monitor expects both outputs low
        repeat (5) @(posedge clk);
        for (int i = 0; i < n_directed; i++) begin
            drive_pair(case_table[i], i);
            drive_idle();
        end
        // Back-to-back random pairs keep three items in flight
        for (int i = 0; i < RANDOM_CASES; i++) begin
            random_aligned_pair(p);
            drive_pair(p, n_directed + i);
        end
        drive_idle();
        waited = 0;
        while (exp_flags.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_flags.size() != 0) begin
            $display("ERROR: timed out with %0d results still pending", exp_flags.size());
            other_count++;
        end
        // A few more cycles to catch a stray out_valid
        repeat (6) @(posedge clk);
        $display("Result: %0d results, %0d mismatches, %0d other errors",
                 results_seen, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+sim
src/sat_fixed_pkg.sv
src/sat_geom_pkg.sv
src/corner_if.sv
src/proj_if.sv
src/corner_gen.sv
src/axis_project.sv
src/separation_test.sv
src/collision_detector.sv
sim/tb_collision_detector.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the collision detector testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -sv -Wno-fatal --timescale 1ns/1ps \
    -f filelist.f --top-module tb_collision_detector \
    --Mdir obj_dir -o tb_collision_detector
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_collision_detector > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0
